// File: tests/stim_core.txt
// Columns: instr_pc_st_addr_wdata_be, one executed instruction per line in run order
// st is the store flag, addr and wdata count only when st is 1, be is 0 for non-stores
123450B7_00000000_0_00000000_00000000_0 // LUI x1, 0x12345
00102023_00000004_1_00000000_12345000_F // SW x1, 0(x0)
00001117_00000008_0_00000000_00000000_0 // AUIPC x2, 1
00202223_0000000C_1_00000004_00001008_F // SW x2, 4(x0)
FD800193_00000010_0_00000000_00000000_0 // ADDI x3, x0, -40
00300213_00000014_0_00000000_00000000_0 // ADDI x4, x0, 3
403202B3_00000018_0_00000000_00000000_0 // SUB x5, x4, x3
4041D333_0000001C_0_00000000_00000000_0 // SRA x6, x3, x4
00502423_00000020_1_00000008_0000002B_F // SW x5, 8(x0)
00602623_00000024_1_0000000C_FFFFFFFB_F // SW x6, 12(x0)
FA500393_00000028_0_00000000_00000000_0 // ADDI x7, x0, -91
047000A3_0000002C_1_00000041_A5A5A5A5_2 // SB x7, 0x41(x0)
047001A3_00000030_1_00000043_A5A5A5A5_8 // SB x7, 0x43(x0)
04701223_00000034_1_00000044_FFA5FFA5_3 // SH x7, 0x44(x0)
04701323_00000038_1_00000046_FFA5FFA5_C // SH x7, 0x46(x0)
04100403_0000003C_0_00000000_00000000_0 // LB x8, 0x41(x0)
00802823_00000040_1_00000010_FFFFFFA5_F // SW x8, 0x10(x0)
04605483_00000044_0_00000000_00000000_0 // LHU x9, 0x46(x0)
00902A23_00000048_1_00000014_0000FFA5_F // SW x9, 0x14(x0)
00320463_0000004C_0_00000000_00000000_0 // BEQ x4, x3, +8 not taken
00420463_00000050_0_00000000_00000000_0 // BEQ x4, x4, +8 taken
00421463_00000058_0_00000000_00000000_0 // BNE x4, x4, +8 not taken
00321663_0000005C_0_00000000_00000000_0 // BNE x4, x3, +12 taken
00324463_00000068_0_00000000_00000000_0 // BLT x4, x3, +8 not taken
0041C463_0000006C_0_00000000_00000000_0 // BLT x3, x4, +8 taken
0041D463_00000074_0_00000000_00000000_0 // BGE x3, x4, +8 not taken
00325463_00000078_0_00000000_00000000_0 // BGE x4, x3, +8 taken
0041E463_00000080_0_00000000_00000000_0 // BLTU x3, x4, +8 not taken
00326463_00000084_0_00000000_00000000_0 // BLTU x4, x3, +8 taken
00327463_0000008C_0_00000000_00000000_0 // BGEU x4, x3, +8 not taken
0041F463_00000090_0_00000000_00000000_0 // BGEU x3, x4, +8 taken
0100056F_00000098_0_00000000_00000000_0 // JAL x10, +16
00A02C23_000000A8_1_00000018_0000009C_F // SW x10, 0x18(x0)
02950667_000000AC_0_00000000_00000000_0 // JALR x12, 0x29(x10)
00C02E23_000000C4_1_0000001C_000000B0_F // SW x12, 0x1C(x0)
00500013_000000C8_0_00000000_00000000_0 // ADDI x0, x0, 5
02002023_000000CC_1_00000020_00000000_F // SW x0, 0x20(x0)

// File: tb.f
hdl/rvPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/loadStoreAlign.sv
hdl/nextPc.sv
hdl/rvCore.sv
tests/tbRvCore.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tbRvCore -o VtbRvCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VtbRvCore > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: tests/tbRvCore.sv
module tbRvCore;
    timeunit 1ns;
    timeprecision 1ps;

    import rvPkg::*;

    localparam int maxSteps = 64;
    localparam int memWords = 64;

    logic    clk;
    logic    reset;
    word_t   instr;
    word_t   pc;
    word_t   dMemAddr;
    word_t   dMemWdata;
    byteEn_t dMemBe;
    logic    dMemWe;
    word_t   dMemRdata;

    // Stim entry: instr, pc, store flag, addr, wdata, byte enable
    logic [135:0] stimMem [maxSteps];
    word_t        dataMem [memWords];
    int           numSteps;
    int           cycleCount = 0;

    rvCore #(.resetPc(32'h0000_0000)) i_dut (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pc(pc),
        .dMemAddr(dMemAddr),
        .dMemWdata(dMemWdata),
        .dMemBe(dMemBe),
        .dMemWe(dMemWe),
        .dMemRdata(dMemRdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Data memory model, word lines picked by address bits 7:2
    assign dMemRdata = dataMem[dMemAddr[7:2]];

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int w = 0; w < memWords; w++)
                dataMem[w] <= $urandom();
        end
        else if (dMemWe)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (dMemBe[b])
                    dataMem[dMemAddr[7:2]][8*b +: 8] <= dMemWdata[8*b +: 8];
            end
        end
    end

    // Run limit grows with the program length
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > numSteps + 20)
        begin
            $display("Timeout: run did not finish within %0d cycles", numSteps + 20);
            $display("RESULT: FAIL");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    initial
    begin
        logic [135:0] entry;

        void'($urandom(32'ha91b3caf));
        reset    = 1'b1;
        instr    = '0;
        numSteps = 0;

        for (int i = 0; i < maxSteps; i++)
            stimMem[i] = '0;
        $readmemh("tests/stim_core.txt", stimMem);

        // Program ends at the first all-zero instruction word
        while (numSteps < maxSteps && stimMem[numSteps][135:104] != '0)
            numSteps++;
        if (numSteps == 0)
        begin
            $display("No instructions found in the stimulus file");
            $display("RESULT: FAIL");
            $fatal(1, "Empty stimulus");
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkValue("reset pc", 32'h0, pc);
        checkValue("reset dMemWe", 32'h0, {31'b0, dMemWe});

        for (int step = 0; step < numSteps; step++)
        begin
            entry = stimMem[step];
            checkValue($sformatf("step %0d pc", step), entry[103:72], pc);
            instr = entry[135:104];
            // Let the combinational path settle
            #10;
            checkValue($sformatf("step %0d store flag", step),
                {28'b0, entry[71:68]}, {31'b0, dMemWe});
            checkValue($sformatf("step %0d byte enable", step),
                {28'b0, entry[3:0]}, {28'b0, dMemBe});
            if (entry[68])
            begin
                checkValue($sformatf("step %0d store addr", step), entry[67:36], dMemAddr);
                checkValue($sformatf("step %0d store data", step), entry[35:4], dMemWdata);
            end
            @(negedge clk);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/rvCore.sv
module rvCore #(
    parameter rvPkg::word_t resetPc = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  rvPkg::word_t   instr,
    output rvPkg::word_t   pc,
    output rvPkg::word_t   dMemAddr,
    output rvPkg::word_t   dMemWdata,
    output rvPkg::byteEn_t dMemBe,
    output logic           dMemWe,
    input  rvPkg::word_t   dMemRdata
);
    import rvPkg::*;

    regAddr_t   rs1;
    regAddr_t   rs2;
    regAddr_t   rd;
    word_t      imm;
    aluOp_t     aluOp;
    logic       aluSrcImm;
    logic       aluSrcPc;
    logic       regWe;
    wbSel_t     wbSel;
    logic       isBranch;
    logic       isJal;
    logic       isJalr;
    logic       isLoad;
    logic       isStore;
    logic [2:0] funct3;
    word_t      rs1Data;
    word_t      rs2Data;
    word_t      operandA;
    word_t      operandB;
    word_t      aluResult;
    word_t      loadData;
    word_t      pcPlus4;
    word_t      rdData;

    instrDecoder i_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .regWe(regWe), .wbSel(wbSel),
        .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr), .isLoad(isLoad),
        .isStore(isStore), .funct3(funct3)
    );

    regFile i_regFile (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .rdData(rdData),
        .regWe(regWe), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // Operand muxes
    assign operandA = aluSrcPc  ? pc  : rs1Data;
    assign operandB = aluSrcImm ? imm : rs2Data;

    alu i_alu (.a(operandA), .b(operandB), .aluOp(aluOp), .result(aluResult));

    loadStoreAlign i_lsAlign (
        .addrLow(aluResult[1:0]), .funct3(funct3), .isStore(isStore),
        .storeData(rs2Data), .memRdata(dMemRdata), .byteEn(dMemBe),
        .memWdata(dMemWdata), .loadData(loadData)
    );

    nextPc #(.resetPc(resetPc)) i_nextPc (
        .clk(clk), .reset(reset), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .funct3(funct3), .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
        .jalrBase(aluResult), .pc(pc), .pcPlus4(pcPlus4)
    );

    // Address bus quiet unless memory is accessed
    assign dMemAddr = (isLoad || isStore) ? aluResult : '0;
    assign dMemWe   = isStore;

    always_comb
    begin
        case (wbSel)
            WB_LOAD: rdData = loadData;
            WB_PC4:  rdData = pcPlus4;
            WB_IMM:  rdData = imm;
            default: rdData = aluResult;
        endcase
    end

endmodule

// File: hdl/nextPc.sv
module nextPc #(
    parameter rvPkg::word_t resetPc = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         reset,
    input  rvPkg::word_t rs1Data,
    input  rvPkg::word_t rs2Data,
    input  rvPkg::word_t imm,
    input  logic [2:0]   funct3,
    input  logic         isBranch,
    input  logic         isJal,
    input  logic         isJalr,
    input  rvPkg::word_t jalrBase,
    output rvPkg::word_t pc,
    output rvPkg::word_t pcPlus4
);
    import rvPkg::*;

    word_t pcNext;
    logic  taken;

    // Branch condition from funct3
    always_comb
    begin
        case (funct3)
            3'b000:  taken = (rs1Data == rs2Data);
            3'b001:  taken = (rs1Data != rs2Data);
            3'b100:  taken = ($signed(rs1Data) < $signed(rs2Data));
            3'b101:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            3'b110:  taken = (rs1Data < rs2Data);
            3'b111:  taken = (rs1Data >= rs2Data);
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb
    begin
        if (isJalr)
            pcNext = {jalrBase[31:1], 1'b0};
        else if (isJal || (isBranch && taken))
            pcNext = pc + imm;
        else
            pcNext = pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= resetPc;
        else
            pc <= pcNext;
    end

endmodule

// File: hdl/loadStoreAlign.sv
module loadStoreAlign (
    input  logic [1:0]     addrLow,
    input  logic [2:0]     funct3,
    input  logic           isStore,
    input  rvPkg::word_t   storeData,
    input  rvPkg::word_t   memRdata,
    output rvPkg::byteEn_t byteEn,
    output rvPkg::word_t   memWdata,
    output rvPkg::word_t   loadData
);
    import rvPkg::*;

    byteEn_t    storeMask;
    logic [7:0] loadByte;
    logic [15:0] loadHalf;

    // Store lanes: mask shifted by the byte offset, data copied to all lanes
    always_comb
    begin
        case (funct3[1:0])
            2'b00:
            begin
                storeMask = byteEn_t'(4'b0001 << addrLow);
                memWdata  = {4{storeData[7:0]}};
            end
            2'b01:
            begin
                storeMask = byteEn_t'(4'b0011 << addrLow);
                memWdata  = {2{storeData[15:0]}};
            end
            default:
            begin
                storeMask = 4'b1111;
                memWdata  = storeData;
            end
        endcase
    end

    assign byteEn = isStore ? storeMask : '0;

    // Pick the addressed lane out of the read word
    assign loadByte = memRdata[8*addrLow +: 8];
    assign loadHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];

    always_comb
    begin
        case (funct3)
            F3_BYTE:   loadData = {{24{loadByte[7]}}, loadByte};
            F3_HALF:   loadData = {{16{loadHalf[15]}}, loadHalf};
            F3_BYTE_U: loadData = {24'b0, loadByte};
            F3_HALF_U: loadData = {16'b0, loadHalf};
            F3_WORD:   loadData = memRdata;
            default:   loadData = memRdata;
        endcase
    end

endmodule

// File: hdl/alu.sv
module alu (
    input  rvPkg::word_t  a,
    input  rvPkg::word_t  b,
    input  rvPkg::aluOp_t aluOp,
    output rvPkg::word_t  result
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    // Shift amount from the low five bits only
    assign shamt        = b[4:0];
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb
    begin
        case (aluOp)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, lessSigned};
            ALU_SLTU: result = {31'b0, lessUnsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// File: hdl/regFile.sv
module regFile (
    input  logic            clk,
    input  logic            reset,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  rvPkg::word_t    rdData,
    input  logic            regWe,
    output rvPkg::word_t    rs1Data,
    output rvPkg::word_t    rs2Data
);
    import rvPkg::*;

    localparam int numRegs = 32;

    word_t regs [numRegs];

    // Single write port that skips x0
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < numRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (regWe && (rd != '0))
        begin
            regs[rd] <= rdData;
        end
    end

    // Combinational reads
    // x0 keeps the zero it got at reset
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

// File: hdl/instrDecoder.sv
module instrDecoder (
    input  rvPkg::word_t    instr,
    output rvPkg::regAddr_t rs1,
    output rvPkg::regAddr_t rs2,
    output rvPkg::regAddr_t rd,
    output rvPkg::word_t    imm,
    output rvPkg::aluOp_t   aluOp,
    output logic            aluSrcImm,
    output logic            aluSrcPc,
    output logic            regWe,
    output rvPkg::wbSel_t   wbSel,
    output logic            isBranch,
    output logic            isJal,
    output logic            isJalr,
    output logic            isLoad,
    output logic            isStore,
    output logic [2:0]      funct3
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic       funct7Bit30;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;
    aluOp_t     regAluOp;

    // Register fields sit at fixed positions in every format
    assign opcode      = instr[6:0];
    assign rd          = instr[11:7];
    assign funct3      = instr[14:12];
    assign rs1         = instr[19:15];
    assign rs2         = instr[24:20];
    assign funct7Bit30 = instr[30];

    // Sign-extended immediates, one per format
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU operation from funct3, bit 30 picks SUB and SRA
    always_comb
    begin
        case (funct3)
            3'b000:  regAluOp = funct7Bit30 ? ALU_SUB : ALU_ADD;
            3'b001:  regAluOp = ALU_SLL;
            3'b010:  regAluOp = ALU_SLT;
            3'b011:  regAluOp = ALU_SLTU;
            3'b100:  regAluOp = ALU_XOR;
            3'b101:  regAluOp = funct7Bit30 ? ALU_SRA : ALU_SRL;
            3'b110:  regAluOp = ALU_OR;
            default: regAluOp = ALU_AND;
        endcase
    end

    always_comb
    begin
        // Defaults describe a harmless no-op
        imm       = '0;
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        aluSrcPc  = 1'b0;
        regWe     = 1'b0;
        wbSel     = WB_ALU;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;

        case (opcode)
            OPC_LUI:
            begin
                imm   = immU;
                regWe = 1'b1;
                wbSel = WB_IMM;
            end
            OPC_AUIPC:
            begin
                // pc + upper immediate through the ALU
                imm       = immU;
                aluSrcPc  = 1'b1;
                aluSrcImm = 1'b1;
                regWe     = 1'b1;
            end
            OPC_JAL:
            begin
                imm   = immJ;
                regWe = 1'b1;
                wbSel = WB_PC4;
                isJal = 1'b1;
            end
            OPC_JALR:
            begin
                // ALU forms rs1 + imm as the jump base
                imm       = immI;
                aluSrcImm = 1'b1;
                regWe     = 1'b1;
                wbSel     = WB_PC4;
                isJalr    = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm      = immB;
                isBranch = 1'b1;
            end
            OPC_LOAD:
            begin
                imm       = immI;
                aluSrcImm = 1'b1;
                regWe     = 1'b1;
                wbSel     = WB_LOAD;
                isLoad    = 1'b1;
            end
            OPC_STORE:
            begin
                imm       = immS;
                aluSrcImm = 1'b1;
                isStore   = 1'b1;
            end
            OPC_OPIMM:
            begin
                imm       = immI;
                aluSrcImm = 1'b1;
                regWe     = 1'b1;
                // No SUBI, bit 30 is part of the immediate for ADDI
                aluOp     = (funct3 == 3'b000) ? ALU_ADD : regAluOp;
            end
            OPC_OP:
            begin
                regWe = 1'b1;
                aluOp = regAluOp;
            end
            default:
            begin
                regWe = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/rvPkg.sv
package rvPkg;

    // Data, address and instruction words
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] regAddr_t;

    // One enable bit per byte lane of the data bus
    typedef logic [3:0] byteEn_t;

    // ALU operation select
    typedef logic [3:0] aluOp_t;

    // Writeback source select
    typedef logic [1:0] wbSel_t;

    // Base opcodes of the supported RV32I instructions
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU operations
    localparam aluOp_t ALU_ADD  = 4'd0;
    localparam aluOp_t ALU_SUB  = 4'd1;
    localparam aluOp_t ALU_SLL  = 4'd2;
    localparam aluOp_t ALU_SLT  = 4'd3;
    localparam aluOp_t ALU_SLTU = 4'd4;
    localparam aluOp_t ALU_XOR  = 4'd5;
    localparam aluOp_t ALU_SRL  = 4'd6;
    localparam aluOp_t ALU_SRA  = 4'd7;
    localparam aluOp_t ALU_OR   = 4'd8;
    localparam aluOp_t ALU_AND  = 4'd9;

    // Writeback sources
    localparam wbSel_t WB_ALU  = 2'd0;
    localparam wbSel_t WB_LOAD = 2'd1;
    localparam wbSel_t WB_PC4  = 2'd2;
    localparam wbSel_t WB_IMM  = 2'd3;

    // funct3 encodings shared by loads and stores
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

endpackage
